// ==== verif/read_cases.txt ====
// Columns: start address, size in bytes, stall flag (all hex)
// An address of ffffffff ends the list
00000000 1000 1
00000ff0 0020 0
00002000 0000 0
00003004 0007 1
00004800 0c00 0
00006100 0404 1
00007ffc 0008 0
00008000 0010 1
0000a000 0100 0
ffffffff 0000 0

// ==== sources.f ====
+incdir+include
rtl/axi_rd_pkg.sv
rtl/xfer_pkg.sv
rtl/req_queue.sv
rtl/page_splitter.sv
rtl/burst_issuer.sv
rtl/rd_completion.sv
rtl/axi_read_master.sv
verif/axi_read_master_sva.sv
verif/rd_checker.sv
verif/tb_axi_read_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_axi_read_master -f sources.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation stopped with an error" >> sim.log
grep -q "^Test OK$" sim.log \
  && echo "PASS" \
  || { cat sim.log; echo "FAIL"; exit 1; }

// ==== verif/tb_axi_read_master.sv ====
/*
 * Testbench for the AXI read master
 * Loads requests from the case file, models a memory slave
 * and leaves all comparing to rd_checker
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module tb_axi_read_master;

  import axi_rd_pkg::*;

  localparam int MAX_CASES  = 32;
  localparam int WORD_BYTES = `RDM_DATA_W / 8;

  // DUT inputs start at known values
  logic                   aclk       = 1'b0;
  logic                   areset     = 1'b1;
  logic                   ctrl_start = 1'b0;
  addr_t                  ctrl_addr  = '0;
  logic [`RDM_SIZE_W-1:0] ctrl_size  = '0;
  logic                   arready    = 1'b0;
  logic                   rvalid     = 1'b0;
  data_t                  rdata      = '0;
  logic                   rlast      = 1'b0;
  logic                   tready     = 1'b0;

  logic   req_ready;
  logic   ctrl_done;
  logic   arvalid;
  addr_t  araddr;
  arlen_t arlen;
  logic   rready;
  logic   tvalid;
  data_t  tdata;
  logic   tlast;

  // Case file contents, three words per request
  logic [31:0] case_mem [3*MAX_CASES];
  logic        case_stall [MAX_CASES];
  int          num_cases = 0;

  // Slave model state
  addr_t       ar_addr_q [$];
  int          ar_beats_q [$];
  logic        rd_active  = 1'b0;
  logic        r_hold     = 1'b0;
  addr_t       beat_addr  = '0;
  int          beats_left = 0;
  int          dones      = 0;
  integer      seed       = 32'hbcdb;
  logic [31:0] rnd;
  logic        stall;

  int error_count;
  int done_count;
  int burst_count;
  int beat_count;

  always #20 aclk = ~aclk;

  axi_read_master u_axi_read_master (.*);

  rd_checker u_rd_checker (
    .total_cases (num_cases),
    .*
  );

  ////////////////////////////////////////////////////////////
  // Memory slave model
  ////////////////////////////////////////////////////////////

  // Bookkeeping on the rising edge, where handshakes complete
  always @(posedge aclk) begin
    if (areset) begin
      rd_active = 1'b0;
      r_hold    = 1'b0;
      dones     = 0;
    end else begin
      if (arvalid && arready) begin
        ar_addr_q.push_back(araddr);
        ar_beats_q.push_back(int'(arlen) + 1);
      end
      // Beat offered but not taken must stay up
      r_hold = rvalid && !rready;
      if (rvalid && rready) begin
        beat_addr  = beat_addr + addr_t'(WORD_BYTES);
        beats_left = beats_left - 1;
        if (beats_left == 0)
          rd_active = 1'b0;
      end
      // Next accepted burst, in order
      if (!rd_active && ar_addr_q.size() > 0) begin
        beat_addr  = ar_addr_q.pop_front();
        beats_left = ar_beats_q.pop_front();
        rd_active  = 1'b1;
      end
      if (ctrl_done)
        dones = dones + 1;
    end
  end

  // Stall mode follows the oldest request still in flight
  always @(negedge aclk) begin
    rnd     = $random(seed);
    stall   = (dones < num_cases) && case_stall[dones];
    arready <= stall ? rnd[0] : 1'b1;
    tready  <= stall ? rnd[1] : 1'b1;
    rvalid  <= r_hold || (rd_active && (!stall || rnd[2]));
    // Data word equals its own byte address
    rdata   <= beat_addr;
    rlast   <= (beats_left == 1);
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic load_cases();
    $readmemh("verif/read_cases.txt", case_mem);
    // List ends at an address of all ones
    while (num_cases < MAX_CASES && case_mem[3*num_cases] != 32'hffff_ffff) begin
      case_stall[num_cases] = case_mem[3*num_cases+2][0];
      num_cases = num_cases + 1;
    end
  endtask

  // Back to back starts, each one only while the queue has room
  task automatic send_cases();
    for (int i = 0; i < num_cases; i++) begin
      while (req_ready !== 1'b1)
        @(negedge aclk);
      ctrl_start = 1'b1;
      ctrl_addr  = case_mem[3*i];
      ctrl_size  = case_mem[3*i+1][`RDM_SIZE_W-1:0];
      @(negedge aclk);
      ctrl_start = 1'b0;
    end
  endtask

  initial begin
    load_cases();
    if (num_cases == 0 || num_cases == MAX_CASES) begin
      $display("case file could not be read or has no end marker");
      $display("Test FAILED");
      $finish;
    end else begin
      repeat (4) @(posedge aclk);
      @(negedge aclk);
      areset = 1'b0;
      send_cases();
      wait (done_count == num_cases);
      repeat (2) @(posedge aclk);
      $display("errors=%0d requests=%0d bursts=%0d beats=%0d",
               error_count, done_count, burst_count, beat_count);
      if (error_count == 0)
        $display("Test OK");
      else
        $display("Test FAILED");
      $finish;
    end
  end

  // Watchdog, scaled by the number of cases
  initial begin
    wait (num_cases > 0);
    repeat (2000 * num_cases + 1000) @(posedge aclk);
    $display("timeout with %0d of %0d requests done", done_count, num_cases);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== verif/rd_checker.sv ====
/*
 * Read master checker
 * Rebuilds the expected bursts and beats of every accepted request
 * and compares them with the AR and stream traffic of the DUT
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module rd_checker (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  axi_rd_pkg::addr_t      ctrl_addr,
  input  logic [`RDM_SIZE_W-1:0] ctrl_size,
  input  logic                   req_ready,
  input  logic                   ctrl_done,
  input  logic                   arvalid,
  input  logic                   arready,
  input  axi_rd_pkg::addr_t      araddr,
  input  axi_rd_pkg::arlen_t     arlen,
  input  logic                   rvalid,
  input  logic                   rready,
  input  logic                   tvalid,
  input  logic                   tready,
  input  axi_rd_pkg::data_t      tdata,
  input  logic                   tlast,
  input  int                     total_cases,
  output int                     error_count,
  output int                     done_count,
  output int                     burst_count,
  output int                     beat_count
);

  import axi_rd_pkg::*;

  localparam int WORD_BYTES = `RDM_DATA_W / 8;

  // Expected AR bursts in issue order
  addr_t exp_ar_addr [$];
  int    exp_ar_beats [$];
  // Start address and beat total per request
  addr_t req_addr_q [$];
  int    req_beats_q [$];
  // Lengths of accepted bursts for the tlast check
  int    burst_len_q [$];

  int    accepted;
  int    outstanding;
  int    req_left;
  int    burst_left;
  addr_t next_data;
  logic  done_due;
  logic  saw_full;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    error_count = error_count + 1;
  endtask

  task automatic report_error(input string what);
    $display("error at %0t ns: %s", $time, what);
    error_count = error_count + 1;
  endtask

  ////////////////////////////////////////////////////////////
  // Burst rule
  ////////////////////////////////////////////////////////////

  // Cut at 4 KB pages, then into bursts of at most 256 beats
  task automatic add_request(input addr_t addr, input int size);
    addr_t seg_addr;
    addr_t burst_addr;
    int    rem;
    int    room;
    int    seg_beats;
    int    n;
    rem = (size == 0) ? WORD_BYTES : size;
    req_addr_q.push_back(addr);
    req_beats_q.push_back((rem + WORD_BYTES - 1) / WORD_BYTES);
    seg_addr = addr;
    while (rem > 0) begin
      room       = `RDM_PAGE_BYTES - int'(seg_addr % `RDM_PAGE_BYTES);
      seg_beats  = ((rem < room ? rem : room) + WORD_BYTES - 1) / WORD_BYTES;
      burst_addr = seg_addr;
      while (seg_beats > 0) begin
        n = (seg_beats > `RDM_MAX_BURST_BEATS) ? `RDM_MAX_BURST_BEATS : seg_beats;
        exp_ar_addr.push_back(burst_addr);
        exp_ar_beats.push_back(n);
        burst_addr = burst_addr + addr_t'(n * WORD_BYTES);
        seg_beats  = seg_beats - n;
      end
      if (rem > room) begin
        seg_addr = seg_addr + addr_t'(room);
        rem      = rem - room;
      end else begin
        rem = 0;
      end
    end
  endtask

  task automatic check_burst();
    int beats;
    beats       = int'(arlen) + 1;
    burst_count = burst_count + 1;
    burst_len_q.push_back(beats);
    if (int'(araddr % `RDM_PAGE_BYTES) + beats * WORD_BYTES > `RDM_PAGE_BYTES)
      report_error("burst crosses a 4 KB page");
    if (exp_ar_addr.size() == 0) begin
      report_error("AR burst issued with no burst expected");
    end else begin
      if (araddr !== exp_ar_addr[0])
        report_mismatch("araddr", araddr, exp_ar_addr[0]);
      if (beats != exp_ar_beats[0])
        report_mismatch("arlen", 32'(arlen), exp_ar_beats[0] - 1);
      void'(exp_ar_addr.pop_front());
      void'(exp_ar_beats.pop_front());
    end
  endtask

  // Beats of a request carry consecutive word addresses
  task automatic check_beat();
    beat_count = beat_count + 1;
    if (req_left == 0 && req_addr_q.size() > 0) begin
      next_data = req_addr_q.pop_front();
      req_left  = req_beats_q.pop_front();
    end
    if (burst_left == 0 && burst_len_q.size() > 0)
      burst_left = burst_len_q.pop_front();
    if (req_left == 0 || burst_left == 0) begin
      report_error("stream beat with no request or burst pending");
    end else begin
      if (tdata !== next_data)
        report_mismatch("tdata", tdata, next_data);
      if (tlast !== (burst_left == 1))
        report_mismatch("tlast", 32'(tlast), 32'(burst_left == 1));
      next_data  = next_data + addr_t'(WORD_BYTES);
      req_left   = req_left - 1;
      burst_left = burst_left - 1;
      // Done due on the next edge
      if (req_left == 0)
        done_due = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (areset) begin
      error_count = 0;
      done_count  = 0;
      burst_count = 0;
      beat_count  = 0;
      accepted    = 0;
      outstanding = 0;
      req_left    = 0;
      burst_left  = 0;
      done_due    = 1'b0;
      saw_full    = 1'b0;
    end else begin
      if (ctrl_done !== done_due)
        report_mismatch("ctrl_done", 32'(ctrl_done), 32'(done_due));
      if (ctrl_done) begin
        done_count = done_count + 1;
        if (done_count == total_cases && total_cases > `RDM_REQ_DEPTH && !saw_full)
          report_error("request queue never filled");
      end
      done_due = 1'b0;
      // R channel passes straight through to the stream
      if (tvalid !== rvalid)
        report_mismatch("tvalid", 32'(tvalid), 32'(rvalid));
      if (rready !== tready)
        report_mismatch("rready", 32'(rready), 32'(tready));
      // Full queue plus the request held in the splitter are all unfinished
      if (!req_ready) begin
        saw_full = 1'b1;
        if (accepted - done_count <= `RDM_REQ_DEPTH)
          report_error("req_ready low while the queue has free entries");
      end
      if (ctrl_start && req_ready) begin
        accepted = accepted + 1;
        add_request(ctrl_addr, int'(ctrl_size));
      end
      if (arvalid && arready) begin
        check_burst();
        outstanding = outstanding + 1;
      end
      if (tvalid && tready) begin
        check_beat();
        if (tlast)
          outstanding = outstanding - 1;
      end
      if (outstanding > `RDM_MAX_OUTSTANDING)
        report_error($sformatf("%0d bursts outstanding", outstanding));
    end
  end

endmodule

// ==== verif/axi_read_master_sva.sv ====
/*
 * Read master assertions
 * AR channel stability, page safety and done timing
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module axi_read_master_sva (
  input logic               aclk,
  input logic               areset,
  input logic               arvalid,
  input logic               arready,
  input axi_rd_pkg::addr_t  araddr,
  input axi_rd_pkg::arlen_t arlen,
  input logic               tvalid,
  input logic               tready,
  input logic               tlast,
  input logic               ctrl_done
);

  // Address and length hold while the slave stalls
  a_ar_hold: assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else $error("AR channel changed before arready");

  // Burst stays inside one page
  a_ar_page: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> int'(araddr % `RDM_PAGE_BYTES) + (int'(arlen) + 1) * (`RDM_DATA_W / 8)
                <= `RDM_PAGE_BYTES)
    else $error("AR burst crosses a 4 KB page");

  // Each done cycle follows a burst's last beat
  a_done_after_last: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |-> $past(tvalid && tready && tlast))
    else $error("ctrl_done without a preceding last beat");

  a_reset_idle: assert property (@(posedge aclk)
    areset |=> !arvalid && !ctrl_done)
    else $error("arvalid or ctrl_done high after reset");

endmodule

bind axi_read_master axi_read_master_sva u_axi_read_master_sva (.*);

// ==== rtl/axi_read_master.sv ====
/*
 * AXI read master top level
 * Queues start requests, splits them into page-safe bursts
 * and passes read data straight to a stream output
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module axi_read_master (
  input  logic                    aclk,
  input  logic                    areset,
  // Request side
  input  logic                    ctrl_start,
  input  axi_rd_pkg::addr_t       ctrl_addr,
  input  logic [`RDM_SIZE_W-1:0]  ctrl_size,
  output logic                    req_ready,
  output logic                    ctrl_done,
  // AR channel
  output logic                    arvalid,
  input  logic                    arready,
  output axi_rd_pkg::addr_t       araddr,
  output axi_rd_pkg::arlen_t      arlen,
  // R channel
  input  logic                    rvalid,
  output logic                    rready,
  input  axi_rd_pkg::data_t       rdata,
  input  logic                    rlast,
  // Stream output
  output logic                    tvalid,
  input  logic                    tready,
  output axi_rd_pkg::data_t       tdata,
  output logic                    tlast
);

  import axi_rd_pkg::*;
  import xfer_pkg::*;

  logic  q_valid;
  logic  q_pop;
  addr_t q_addr;
  size_t q_size;
  logic  seg_valid;
  logic  seg_take;
  logic  seg_last;
  addr_t seg_addr;
  size_t seg_size;
  logic  has_slot;
  logic  ar_fire;
  logic  ar_req_end;
  logic  r_end;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  req_queue #(
    .DEPTH (`RDM_REQ_DEPTH)
  ) u_req_queue (
    .aclk      (aclk),
    .areset    (areset),
    .push      (ctrl_start),
    .push_addr (ctrl_addr),
    .push_size (ctrl_size),
    .q_pop     (q_pop),
    .q_valid   (q_valid),
    .q_addr    (q_addr),
    .q_size    (q_size),
    .req_ready (req_ready)
  );

  page_splitter u_page_splitter (
    .aclk      (aclk),
    .areset    (areset),
    .q_valid   (q_valid),
    .q_addr    (q_addr),
    .q_size    (q_size),
    .seg_take  (seg_take),
    .q_pop     (q_pop),
    .seg_valid (seg_valid),
    .seg_addr  (seg_addr),
    .seg_size  (seg_size),
    .seg_last  (seg_last)
  );

  burst_issuer u_burst_issuer (
    .aclk       (aclk),
    .areset     (areset),
    .seg_valid  (seg_valid),
    .seg_addr   (seg_addr),
    .seg_size   (seg_size),
    .seg_last   (seg_last),
    .arready    (arready),
    .has_slot   (has_slot),
    .seg_take   (seg_take),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arlen      (arlen),
    .ar_fire    (ar_fire),
    .ar_req_end (ar_req_end)
  );

  ////////////////////////////////////////////////////////////
  // Data path and completion
  ////////////////////////////////////////////////////////////

  // R channel straight through to the stream
  assign tvalid = rvalid;
  assign tdata  = rdata;
  assign tlast  = rlast;
  assign rready = tready;

  // Last beat of a burst actually transferred
  assign r_end = rvalid && tready && rlast;

  rd_completion #(
    .MAX_OUTST (`RDM_MAX_OUTSTANDING)
  ) u_rd_completion (
    .aclk       (aclk),
    .areset     (areset),
    .ar_fire    (ar_fire),
    .ar_req_end (ar_req_end),
    .r_end      (r_end),
    .has_slot   (has_slot),
    .ctrl_done  (ctrl_done)
  );

endmodule

// ==== rtl/rd_completion.sv ====
/*
 * Read completion tracker
 * Limits bursts in flight and pulses done at the last beat of a request
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module rd_completion #(
  parameter int MAX_OUTST = `RDM_MAX_OUTSTANDING
) (
  input  logic aclk,
  input  logic areset,
  input  logic ar_fire,
  input  logic ar_req_end,
  input  logic r_end,
  output logic has_slot,
  output logic ctrl_done
);

  import xfer_pkg::*;

  localparam int PTR_W = (MAX_OUTST > 1) ? $clog2(MAX_OUTST) : 1;

  outst_t vacancy;

  // One request-end flag per burst, in issue order
  logic             end_flag [MAX_OUTST];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(MAX_OUTST - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign has_slot = (vacancy != '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy   <= outst_t'(MAX_OUTST);
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      ctrl_done <= 1'b0;
    end else begin
      // Burst issued takes a slot, burst drained returns one
      if (ar_fire && !r_end)
        vacancy <= vacancy - 1'b1;
      else if (r_end && !ar_fire)
        vacancy <= vacancy + 1'b1;
      if (ar_fire)
        wr_ptr <= next_ptr(wr_ptr);
      if (r_end)
        rd_ptr <= next_ptr(rd_ptr);
      // Single cycle pulse after the request's last beat
      ctrl_done <= r_end && end_flag[rd_ptr];
    end
  end

  // Queue never overflows, vacancy bounds it
  always_ff @(posedge aclk) begin
    if (ar_fire)
      end_flag[wr_ptr] <= ar_req_end;
  end

endmodule

// ==== rtl/burst_issuer.sv ====
/*
 * Burst issuer
 * Turns page segments into AR bursts of up to 256 beats
 * Drives the read address channel and flags the end of each request
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module burst_issuer (
  input  logic               aclk,
  input  logic               areset,
  input  logic               seg_valid,
  input  axi_rd_pkg::addr_t  seg_addr,
  input  xfer_pkg::size_t    seg_size,
  input  logic               seg_last,
  input  logic               arready,
  input  logic               has_slot,
  output logic               seg_take,
  output logic               arvalid,
  output axi_rd_pkg::addr_t  araddr,
  output axi_rd_pkg::arlen_t arlen,
  output logic               ar_fire,
  output logic               ar_req_end
);

  import axi_rd_pkg::*;
  import xfer_pkg::*;

  localparam int     LOG_WORD    = $clog2(`RDM_DATA_W / 8);
  localparam beats_t MAX_BEATS   = beats_t'(`RDM_MAX_BURST_BEATS);
  // Address step after a full burst, 1 KB on a 32-bit bus
  localparam addr_t  BURST_BYTES = addr_t'(`RDM_MAX_BURST_BEATS * (`RDM_DATA_W / 8));

  beats_t seg_beats;
  beats_t beats_left;
  beats_t cur_beats;
  addr_t  cur_addr;
  logic   req_last;
  logic   final_burst;

  ////////////////////////////////////////////////////////////
  // Beat arithmetic
  ////////////////////////////////////////////////////////////

  // Bytes to beats, partial word rounds up
  assign seg_beats = beats_t'(seg_size >> LOG_WORD) + beats_t'(|seg_size[LOG_WORD-1:0]);

  // Remainder burst once 256 or fewer beats are left
  assign final_burst = (beats_left <= MAX_BEATS);
  assign cur_beats   = final_burst ? beats_left : MAX_BEATS;

  ////////////////////////////////////////////////////////////
  // AR channel
  ////////////////////////////////////////////////////////////

  // New segment only after the previous one is fully issued
  assign seg_take = seg_valid && (beats_left == '0);

  assign araddr     = cur_addr;
  assign arlen      = arlen_t'(cur_beats - beats_t'(1));
  assign ar_fire    = arvalid && arready;
  assign ar_req_end = ar_fire && final_burst && req_last;

  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid    <= 1'b0;
      beats_left <= '0;
    end else begin
      if (seg_take)
        beats_left <= seg_beats;
      else if (ar_fire)
        beats_left <= beats_left - cur_beats;

      // Hold until accepted, raise again only with a free slot
      if (arvalid)
        arvalid <= !arready;
      else
        arvalid <= has_slot && (seg_take || (beats_left != '0));
    end
  end

  // Burst address and request-end marker
  always_ff @(posedge aclk) begin
    if (seg_take) begin
      cur_addr <= seg_addr;
      req_last <= seg_last;
    end else if (ar_fire) begin
      cur_addr <= cur_addr + BURST_BYTES;
    end
  end

endmodule

// ==== rtl/page_splitter.sv ====
/*
 * Page splitter
 * Cuts a queued request into segments that never cross a 4 KB page
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module page_splitter (
  input  logic              aclk,
  input  logic              areset,
  input  logic              q_valid,
  input  axi_rd_pkg::addr_t q_addr,
  input  xfer_pkg::size_t   q_size,
  input  logic              seg_take,
  output logic              q_pop,
  output logic              seg_valid,
  output axi_rd_pkg::addr_t seg_addr,
  output xfer_pkg::size_t   seg_size,
  output logic              seg_last
);

  import axi_rd_pkg::*;
  import xfer_pkg::*;

  localparam int    PAGE_LOG   = $clog2(`RDM_PAGE_BYTES);
  localparam size_t WORD_BYTES = size_t'(`RDM_DATA_W / 8);

  // Request being split
  logic  busy;
  addr_t cur_addr;
  size_t rem_size;
  // Bytes from cur_addr up to the next page boundary
  size_t page_room;

  ////////////////////////////////////////////////////////////
  // Segment offer
  ////////////////////////////////////////////////////////////

  assign page_room = size_t'(`RDM_PAGE_BYTES) - size_t'(cur_addr[PAGE_LOG-1:0]);

  // Rest fits inside this page, so this is the final piece
  assign seg_last  = (rem_size <= page_room);
  assign seg_size  = seg_last ? rem_size : page_room;
  assign seg_addr  = cur_addr;
  assign seg_valid = busy;

  // Fetch the next request only when idle
  assign q_pop = !busy && q_valid;

  ////////////////////////////////////////////////////////////
  // State update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy <= 1'b0;
    end else if (q_pop) begin
      busy <= 1'b1;
    end else if (seg_take && seg_last) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (q_pop) begin
      cur_addr <= q_addr;
      // Zero size still reads one word
      rem_size <= (q_size == '0) ? WORD_BYTES : q_size;
    end else if (seg_take && !seg_last) begin
      // Continue at the start of the next page
      cur_addr <= cur_addr + addr_t'(page_room);
      rem_size <= rem_size - page_room;
    end
  end

endmodule

// ==== rtl/req_queue.sv ====
/*
 * Request queue
 * Circular FIFO of start address and size pairs, one entry per ctrl_start
 */
`timescale 1ns/1ps
`include "rd_master_defines.svh"

module req_queue #(
  parameter int DEPTH = `RDM_REQ_DEPTH
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             push,
  input  axi_rd_pkg::addr_t push_addr,
  input  xfer_pkg::size_t  push_size,
  input  logic             q_pop,
  output logic             q_valid,
  output axi_rd_pkg::addr_t q_addr,
  output xfer_pkg::size_t  q_size,
  output logic             req_ready
);

  import axi_rd_pkg::*;
  import xfer_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  addr_t addr_mem [DEPTH];
  size_t size_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_ok;
  logic             pop_ok;

  // Wrap at DEPTH, need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Full queue drops the push
  assign req_ready = (count != CNT_W'(DEPTH));
  assign q_valid   = (count != '0);
  assign push_ok   = push && req_ready;
  assign pop_ok    = q_pop && q_valid;

  // Head entry, valid one cycle after its push
  assign q_addr = addr_mem[rd_ptr];
  assign q_size = size_mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop_ok)
        rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop keep the count
      if (push_ok && !pop_ok)
        count <= count + 1'b1;
      else if (pop_ok && !push_ok)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (push_ok) begin
      addr_mem[wr_ptr] <= push_addr;
      size_mem[wr_ptr] <= push_size;
    end
  end

endmodule

// ==== rtl/xfer_pkg.sv ====
/*
 * Transfer bookkeeping types
 * Sizes and counters used between the request queue and the AR channel
 */
`include "rd_master_defines.svh"

package xfer_pkg;

  // Request or segment size in bytes
  typedef logic [`RDM_SIZE_W-1:0] size_t;

  // Beats left in a segment
  typedef logic [`RDM_SIZE_W-1:0] beats_t;

  // Vacancy count, 0 up to the outstanding limit
  typedef logic [$clog2(`RDM_MAX_OUTSTANDING+1)-1:0] outst_t;

endpackage

// ==== rtl/axi_rd_pkg.sv ====
/*
 * AXI read channel types
 * Address, burst length and data beat vectors
 */
`include "rd_master_defines.svh"

package axi_rd_pkg;

  // Byte address on the AR channel
  typedef logic [`RDM_ADDR_W-1:0] addr_t;

  // AXI arlen, beats minus one
  typedef logic [7:0] arlen_t;

  // One R channel beat
  typedef logic [`RDM_DATA_W-1:0] data_t;

endpackage

// ==== include/rd_master_defines.svh ====
/*
 * Read master configuration
 * Bus widths, queue depths and AXI protocol limits
 */
`ifndef RD_MASTER_DEFINES_SVH
`define RD_MASTER_DEFINES_SVH

// Bus widths
`define RDM_ADDR_W 32
`define RDM_DATA_W 32
// Transfer size field in bytes
`define RDM_SIZE_W 16

// No burst may cross this boundary
`define RDM_PAGE_BYTES 4096
// AXI4 INCR limit
`define RDM_MAX_BURST_BEATS 256

// Bursts in flight on the AR channel
`define RDM_MAX_OUTSTANDING 4
// Pending start requests
`define RDM_REQ_DEPTH 4

`endif
